// File: hdl/cpu_pkg.sv
package cpu_pkg;

    // ALU operations carried from decode to execute
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5,
        alu_sll = 4'd6,
        alu_lui = 4'd7
    } alu_op_e;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct field of special opcode
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    localparam logic [4:0] reg_zero = 5'd0;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic        load;
        logic        store;
        logic        rf_we;
        logic [4:0]  dest;
        logic [31:0] st_data;
    } ds_to_es_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic        load;
        logic        rf_we;
        logic [4:0]  dest;
    } es_to_ms_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic        rf_we;
        logic [4:0]  dest;
    } ms_to_ws_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } ws_to_rf_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // result offered by a later stage to decode
    typedef struct packed {
        logic        valid;
        logic        rf_we;
        logic [4:0]  dest;
        logic [31:0] result;
    } fwd_t;

endpackage

// File: hdl/if_stage.sv
`timescale 1ns/1ps

module if_stage #(
    parameter logic [31:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ds_allowin,
    input  cpu_pkg::br_bus_t   br_bus,
    output logic               fs_to_ds_valid,
    output cpu_pkg::fs_to_ds_t fs_to_ds_bus,
    output logic               inst_sram_en,
    output logic [3:0]         inst_sram_wen,
    output logic [31:0]        inst_sram_addr,
    output logic [31:0]        inst_sram_wdata,
    input  logic [31:0]        inst_sram_rdata
);
    logic        fs_valid;
    logic        fs_allowin;
    logic [31:0] fs_pc;
    logic [31:0] nextpc;

    assign fs_allowin = !fs_valid || ds_allowin;

    // taken branch redirects the fetch after the delay slot
    assign nextpc = br_bus.taken ? br_bus.target : fs_pc + 32'd4;

    // start one word early so the first request is RESET_PC
    always_ff @(posedge clk) begin
        if (rst) begin
            fs_valid <= 1'b0;
            fs_pc    <= RESET_PC - 32'd4;
        end else if (fs_allowin) begin
            fs_valid <= 1'b1;
            fs_pc    <= nextpc;
        end
    end

    // hold the address while stalled so rdata stays with fs_pc
    assign inst_sram_en    = fs_allowin;
    assign inst_sram_addr  = fs_allowin ? nextpc : fs_pc;
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_wdata = 32'b0;

    assign fs_to_ds_valid    = fs_valid;
    assign fs_to_ds_bus.pc   = fs_pc;
    assign fs_to_ds_bus.inst = inst_sram_rdata;

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               fs_to_ds_valid,
    input  cpu_pkg::fs_to_ds_t fs_to_ds_bus,
    output logic               ds_allowin,
    input  logic               es_allowin,
    output logic               ds_to_es_valid,
    output cpu_pkg::ds_to_es_t ds_to_es_bus,
    output cpu_pkg::br_bus_t   br_bus,
    output logic [4:0]         rf_raddr1,
    output logic [4:0]         rf_raddr2,
    input  logic [31:0]        rf_rdata1,
    input  logic [31:0]        rf_rdata2,
    input  cpu_pkg::fwd_t      es_fwd,
    input  cpu_pkg::fwd_t      ms_fwd,
    input  cpu_pkg::fwd_t      ws_fwd,
    input  logic               es_load
);
    import cpu_pkg::*;

    logic        ds_valid;
    logic        ds_ready_go;
    fs_to_ds_t   ds_r;
    logic [5:0]  op;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic [31:0] imm_sext;
    logic [31:0] pc_plus4;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic        rs_eq_rt;
    alu_op_e     alu_op;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [4:0]  dest;
    logic        rf_we;
    logic        is_load;
    logic        is_store;
    logic        is_beq;
    logic        is_bne;
    logic        is_j;

    // youngest stage wins, register 0 never forwards
    function automatic logic [31:0] fwd_pick(input logic [4:0] r, input logic [31:0] rf_val,
                                             input fwd_t f_es, input fwd_t f_ms,
                                             input fwd_t f_ws);
        if (r == reg_zero)
            return 32'b0;
        if (f_es.valid && f_es.rf_we && f_es.dest == r)
            return f_es.result;
        if (f_ms.valid && f_ms.rf_we && f_ms.dest == r)
            return f_ms.result;
        if (f_ws.valid && f_ws.rf_we && f_ws.dest == r)
            return f_ws.result;
        return rf_val;
    endfunction

    assign ds_allowin     = !ds_valid || ds_ready_go && es_allowin;
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (rst)
            ds_valid <= 1'b0;
        else if (ds_allowin)
            ds_valid <= fs_to_ds_valid;
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin)
            ds_r <= fs_to_ds_bus;
    end

    assign op       = ds_r.inst[31:26];
    assign rs       = ds_r.inst[25:21];
    assign rt       = ds_r.inst[20:16];
    assign rd       = ds_r.inst[15:11];
    assign funct    = ds_r.inst[5:0];
    assign imm      = ds_r.inst[15:0];
    assign imm_sext = {{16{imm[15]}}, imm};
    assign pc_plus4 = ds_r.pc + 32'd4;

    assign rf_raddr1 = rs;
    assign rf_raddr2 = rt;
    assign rs_value  = fwd_pick(rs, rf_rdata1, es_fwd, ms_fwd, ws_fwd);
    assign rt_value  = fwd_pick(rt, rf_rdata2, es_fwd, ms_fwd, ws_fwd);

    // load result not ready until memory stage
    assign ds_ready_go = !(es_load && es_fwd.dest != reg_zero &&
                           (es_fwd.dest == rs || es_fwd.dest == rt));

    always_comb begin
        alu_op   = alu_add;
        src_a    = rs_value;
        src_b    = rt_value;
        dest     = rd;
        rf_we    = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        is_j     = 1'b0;
        case (op)
            op_special: begin
                rf_we = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sll: begin
                        alu_op = alu_sll;
                        src_a  = {27'b0, ds_r.inst[10:6]};
                    end
                    default: rf_we = 1'b0;
                endcase
            end
            op_addiu: begin
                rf_we = 1'b1;
                dest  = rt;
                src_b = imm_sext;
            end
            op_lui: begin
                rf_we  = 1'b1;
                dest   = rt;
                alu_op = alu_lui;
                src_b  = {16'b0, imm};
            end
            op_lw: begin
                rf_we   = 1'b1;
                is_load = 1'b1;
                dest    = rt;
                src_b   = imm_sext;
            end
            op_sw: begin
                is_store = 1'b1;
                src_b    = imm_sext;
            end
            op_beq:  is_beq = 1'b1;
            op_bne:  is_bne = 1'b1;
            op_j:    is_j   = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        ds_to_es_bus.pc      = ds_r.pc;
        ds_to_es_bus.alu_op  = alu_op;
        ds_to_es_bus.src_a   = src_a;
        ds_to_es_bus.src_b   = src_b;
        ds_to_es_bus.load    = is_load;
        ds_to_es_bus.store   = is_store;
        ds_to_es_bus.rf_we   = rf_we;
        ds_to_es_bus.dest    = dest;
        ds_to_es_bus.st_data = rt_value;
    end

    assign rs_eq_rt     = rs_value == rt_value;
    assign br_bus.taken = ds_valid && ds_ready_go &&
                          (is_j || is_beq && rs_eq_rt || is_bne && !rs_eq_rt);
    assign br_bus.target = is_j ? {pc_plus4[31:28], ds_r.inst[25:0], 2'b00}
                                : pc_plus4 + {imm_sext[29:0], 2'b00};

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic [4:0]         raddr1,
    input  logic [4:0]         raddr2,
    output logic [31:0]        rdata1,
    output logic [31:0]        rdata2,
    input  cpu_pkg::ws_to_rf_t ws_to_rf
);
    import cpu_pkg::*;

    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (ws_to_rf.we && ws_to_rf.waddr != reg_zero)
            regs[ws_to_rf.waddr] <= ws_to_rf.wdata;
    end

    // same-cycle write is visible to the read
    function automatic logic [31:0] read_port(input logic [4:0] raddr);
        if (raddr == reg_zero)
            return 32'b0;
        if (ws_to_rf.we && ws_to_rf.waddr == raddr)
            return ws_to_rf.wdata;
        return regs[raddr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

// File: hdl/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               ds_to_es_valid,
    input  cpu_pkg::ds_to_es_t ds_to_es_bus,
    output logic               es_allowin,
    input  logic               ms_allowin,
    output logic               es_to_ms_valid,
    output cpu_pkg::es_to_ms_t es_to_ms_bus,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_wen,
    output logic [31:0]        data_sram_addr,
    output logic [31:0]        data_sram_wdata,
    output cpu_pkg::fwd_t      es_fwd,
    output logic               es_load
);
    import cpu_pkg::*;

    logic        es_valid;
    ds_to_es_t   es_r;
    logic [31:0] alu_result;

    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;

    always_ff @(posedge clk) begin
        if (rst)
            es_valid <= 1'b0;
        else if (es_allowin)
            es_valid <= ds_to_es_valid;
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin)
            es_r <= ds_to_es_bus;
    end

    always_comb begin
        case (es_r.alu_op)
            alu_add: alu_result = es_r.src_a + es_r.src_b;
            alu_sub: alu_result = es_r.src_a - es_r.src_b;
            alu_and: alu_result = es_r.src_a & es_r.src_b;
            alu_or:  alu_result = es_r.src_a | es_r.src_b;
            alu_xor: alu_result = es_r.src_a ^ es_r.src_b;
            alu_slt: alu_result = {31'b0, $signed(es_r.src_a) < $signed(es_r.src_b)};
            alu_sll: alu_result = es_r.src_b << es_r.src_a[4:0];
            alu_lui: alu_result = {es_r.src_b[15:0], 16'b0};
            default: alu_result = 32'b0;
        endcase
    end

    // request goes out as the access moves into memory
    assign data_sram_en    = es_valid && ms_allowin && (es_r.load || es_r.store);
    assign data_sram_wen   = {4{data_sram_en && es_r.store}};
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = es_r.st_data;

    assign es_to_ms_bus = '{pc: es_r.pc, alu_result: alu_result, load: es_r.load,
                            rf_we: es_r.rf_we, dest: es_r.dest};
    assign es_fwd  = '{valid: es_valid, rf_we: es_r.rf_we, dest: es_r.dest,
                       result: alu_result};
    assign es_load = es_valid && es_r.load;

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               es_to_ms_valid,
    input  cpu_pkg::es_to_ms_t es_to_ms_bus,
    output logic               ms_allowin,
    input  logic               ws_allowin,
    output logic               ms_to_ws_valid,
    output cpu_pkg::ms_to_ws_t ms_to_ws_bus,
    input  logic [31:0]        data_sram_rdata,
    output cpu_pkg::fwd_t      ms_fwd
);
    import cpu_pkg::*;

    logic        ms_valid;
    es_to_ms_t   ms_r;
    logic [31:0] final_result;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (rst)
            ms_valid <= 1'b0;
        else if (ms_allowin)
            ms_valid <= es_to_ms_valid;
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin)
            ms_r <= es_to_ms_bus;
    end

    // load word arrives one cycle after the request
    assign final_result = ms_r.load ? data_sram_rdata : ms_r.alu_result;

    assign ms_to_ws_bus = '{pc: ms_r.pc, result: final_result, rf_we: ms_r.rf_we,
                            dest: ms_r.dest};
    assign ms_fwd = '{valid: ms_valid, rf_we: ms_r.rf_we, dest: ms_r.dest,
                      result: final_result};

endmodule

// File: hdl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               ms_to_ws_valid,
    input  cpu_pkg::ms_to_ws_t ms_to_ws_bus,
    output logic               ws_allowin,
    output cpu_pkg::ws_to_rf_t ws_to_rf,
    output cpu_pkg::fwd_t      ws_fwd,
    output logic [31:0]        debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output logic [4:0]         debug_wb_rf_wnum,
    output logic [31:0]        debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic      ws_valid;
    ms_to_ws_t ws_r;

    // writeback never stalls
    assign ws_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (rst)
            ws_valid <= 1'b0;
        else
            ws_valid <= ms_to_ws_valid;
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid)
            ws_r <= ms_to_ws_bus;
    end

    assign ws_to_rf = '{we: ws_valid && ws_r.rf_we, waddr: ws_r.dest, wdata: ws_r.result};
    assign ws_fwd   = '{valid: ws_valid, rf_we: ws_r.rf_we, dest: ws_r.dest,
                        result: ws_r.result};

    // trace shows only real register updates
    assign debug_wb_pc       = ws_r.pc;
    assign debug_wb_rf_wen   = (ws_to_rf.we && ws_r.dest != reg_zero) ? 4'hf : 4'h0;
    assign debug_wb_rf_wnum  = ws_r.dest;
    assign debug_wb_rf_wdata = ws_r.result;

endmodule

// File: hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [31:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    // handshake between stages
    logic ds_allowin;
    logic es_allowin;
    logic ms_allowin;
    logic ws_allowin;
    logic fs_to_ds_valid;
    logic ds_to_es_valid;
    logic es_to_ms_valid;
    logic ms_to_ws_valid;

    fs_to_ds_t fs_to_ds_bus;
    ds_to_es_t ds_to_es_bus;
    es_to_ms_t es_to_ms_bus;
    ms_to_ws_t ms_to_ws_bus;
    ws_to_rf_t ws_to_rf;
    br_bus_t   br_bus;

    // forwarding paths into decode
    fwd_t es_fwd;
    fwd_t ms_fwd;
    fwd_t ws_fwd;
    logic es_load;

    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;

    if_stage #(.RESET_PC(RESET_PC)) i_if_stage (.*);

    id_stage i_id_stage (.*);

    regfile i_regfile (
        .clk      (clk),
        .raddr1   (rf_raddr1),
        .raddr2   (rf_raddr2),
        .rdata1   (rf_rdata1),
        .rdata2   (rf_rdata2),
        .ws_to_rf (ws_to_rf)
    );

    exe_stage i_exe_stage (.*);

    mem_stage i_mem_stage (.*);

    wb_stage i_wb_stage (.*);

endmodule

// File: verification/tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// architectural model of the program in imem, delay slot included
task automatic run_reference();
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] nxt;
    logic [31:0] tgt;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] res;
    logic [31:0] addr;
    logic [4:0]  wr;
    logic        we;
    logic        taken;
    int          steps;
    for (int i = 0; i < 32; i++)
        ref_regs[i] = 32'h0;
    for (int i = 0; i < 256; i++)
        ref_mem[i] = init_word(8'(i));
    exp_pc.delete();
    exp_num.delete();
    exp_val.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    pc    = RESET_PC;
    npc   = RESET_PC + 32'd4;
    steps = 0;
    while (pc != loop_pc && steps < 4 * total_words) begin
        inst  = imem[imem_index(pc)];
        a     = ref_regs[inst[25:21]];
        b     = ref_regs[inst[20:16]];
        sext  = {{16{inst[15]}}, inst[15:0]};
        we    = 1'b0;
        wr    = inst[15:11];
        res   = 32'h0;
        taken = 1'b0;
        tgt   = pc + 32'd4 + {sext[29:0], 2'b00};
        case (inst[31:26])
            op_special: begin
                we = 1'b1;
                case (inst[5:0])
                    fn_addu: res = a + b;
                    fn_subu: res = a - b;
                    fn_and:  res = a & b;
                    fn_or:   res = a | b;
                    fn_xor:  res = a ^ b;
                    fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fn_sll:  res = b << inst[10:6];
                    default: we = 1'b0;
                endcase
            end
            op_addiu: begin
                we  = 1'b1;
                wr  = inst[20:16];
                res = a + sext;
            end
            op_lui: begin
                we  = 1'b1;
                wr  = inst[20:16];
                res = {inst[15:0], 16'h0};
            end
            op_lw: begin
                addr = a + sext;
                we   = 1'b1;
                wr   = inst[20:16];
                res  = ref_mem[addr[9:2]];
            end
            op_sw: begin
                addr = a + sext;
                ref_mem[addr[9:2]] = b;
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(b);
            end
            op_beq: taken = (a == b);
            op_bne: taken = (a != b);
            op_j: begin
                taken = 1'b1;
                tgt   = {npc[31:28], inst[25:0], 2'b00};
            end
            default: ;
        endcase
        if (we && wr != 5'd0) begin
            ref_regs[wr] = res;
            exp_pc.push_back(pc);
            exp_num.push_back({27'b0, wr});
            exp_val.push_back(res);
        end
        // the delay slot runs before the target
        nxt   = taken ? tgt : npc + 32'd4;
        pc    = npc;
        npc   = nxt;
        steps = steps + 1;
    end
endtask

`endif

// File: verification/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam logic [31:0] RESET_PC = 32'hbfc0_0000;
    localparam int n_pre       = 14;
    localparam int prog_len    = 200;
    localparam int loop_idx    = n_pre + prog_len;
    localparam int total_words = loop_idx + 2;
    localparam int n_programs  = 9;
    localparam logic [31:0] loop_pc = RESET_PC + 32'(4 * loop_idx);

    logic        clk;
    logic        rst;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata = 32'h0;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = 32'h0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [0:1023];
    logic [31:0] dmem [0:255];
    logic [31:0] ref_mem [0:255];
    logic [31:0] ref_regs [0:31];
    logic [9:0]  iaddr_q = 10'h0;
    logic [7:0]  daddr_q = 8'h0;
    logic [31:0] exp_pc[$];
    logic [31:0] exp_num[$];
    logic [31:0] exp_val[$];
    logic [31:0] exp_st_addr[$];
    logic [31:0] exp_st_data[$];
    string       test_name;
    logic        running;
    int          errors;
    int          n_pass;
    int          n_fail;

    cpu_top #(.RESET_PC(RESET_PC)) i_dut (.*);

    function automatic logic [31:0] init_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, 8'hc3};
    endfunction

    function automatic logic [9:0] imem_index(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - RESET_PC;
        return off[11:2];
    endfunction

    `include "tb_iss.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // synchronous SRAMs, read word presented on the falling edge
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++)
                dmem[i] <= init_word(8'(i));
        end else if (data_sram_en && data_sram_wen == 4'hf) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
        if (data_sram_en)
            daddr_q <= data_sram_addr[9:2];
        if (inst_sram_en)
            iaddr_q <= imem_index(inst_sram_addr);
    end

    always @(negedge clk) begin
        inst_sram_rdata <= imem[iaddr_q];
        data_sram_rdata <= dmem[daddr_q];
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    // writeback trace and store requests against the model queues
    always @(negedge clk) begin
        if (running) begin
            check({test_name, " inst_sram_wen"}, 32'h0, {28'b0, inst_sram_wen});
            check({test_name, " inst_sram_wdata"}, 32'h0, inst_sram_wdata);
        end
        if (running && debug_wb_rf_wen != 4'h0) begin
            if (exp_pc.size() == 0) begin
                $display("%s: unexpected register write at pc %h", test_name, debug_wb_pc);
                errors = errors + 1;
            end else begin
                check({test_name, " pc"}, exp_pc.pop_front(), debug_wb_pc);
                check({test_name, " wnum"}, exp_num.pop_front(), {27'b0, debug_wb_rf_wnum});
                check({test_name, " wdata"}, exp_val.pop_front(), debug_wb_rf_wdata);
            end
        end
        if (running && data_sram_en && data_sram_wen != 4'h0) begin
            if (exp_st_addr.size() == 0) begin
                $display("%s: unexpected store to %h", test_name, data_sram_addr);
                errors = errors + 1;
            end else begin
                check({test_name, " st addr"}, exp_st_addr.pop_front(), data_sram_addr);
                check({test_name, " st data"}, exp_st_data.pop_front(), data_sram_wdata);
            end
        end
    end

    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(0, 7));
    endfunction

    function automatic int pick_kind(input int mode);
        int r;
        r = int'($urandom_range(0, 99));
        case (mode)
            1: return (r < 40) ? 9 : int'($urandom_range(0, 8));
            2: return (r < 30) ? 11 + int'($urandom_range(0, 2)) : int'($urandom_range(0, 8));
            3: return (r < 35) ? 10 : (r < 50) ? 9 : int'($urandom_range(0, 8));
            4: return int'($urandom_range(0, 13));
            default: return int'($urandom_range(0, 8));
        endcase
    endfunction

    // 0-5 alu reg ops, 6 sll, 7 addiu, 8 lui, 9 lw, 10 sw, 11 beq, 12 bne, 13 j
    task automatic build_program(input int mode);
        int          kind;
        int          tgt;
        logic        prev_branch;
        logic        was_load;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  last_rt;
        logic [15:0] imm;
        logic [5:0]  fn;
        logic [31:0] ta;
        for (int i = 0; i < 1024; i++)
            imem[i] = 32'h0;
        for (int r = 1; r <= 7; r++) begin
            imem[2 * r - 2] = {op_lui, 5'd0, 5'(r), 16'($urandom)};
            imem[2 * r - 1] = {op_addiu, 5'(r), 5'(r), 16'($urandom)};
        end
        prev_branch = 1'b0;
        was_load    = 1'b0;
        last_rt     = 5'd0;
        for (int i = n_pre; i < loop_idx; i++) begin
            rs   = pick_reg();
            rt   = pick_reg();
            rd   = pick_reg();
            imm  = 16'($urandom);
            kind = pick_kind(mode);
            // no branch in a delay slot, none just before the end loop
            if ((prev_branch || i >= loop_idx - 1) && kind >= 11)
                kind = 0;
            if (mode == 1 && was_load)
                rs = last_rt;
            case (kind)
                0: fn = fn_addu;
                1: fn = fn_subu;
                2: fn = fn_and;
                3: fn = fn_or;
                4: fn = fn_xor;
                default: fn = fn_slt;
            endcase
            tgt = i + 2 + int'($urandom_range(0, 6));
            if (tgt > loop_idx)
                tgt = loop_idx;
            ta = RESET_PC + 32'(4 * tgt);
            if (kind == 11 && $urandom_range(0, 1) == 1)
                rt = rs;
            case (kind)
                6:  imem[i] = {op_special, 5'd0, rt, rd, 5'($urandom_range(0, 31)), fn_sll};
                7:  imem[i] = {op_addiu, rs, rt, imm};
                8:  imem[i] = {op_lui, 5'd0, rt, imm};
                9:  imem[i] = {op_lw, 5'd0, rt, 6'd0, 8'($urandom), 2'b00};
                10: imem[i] = {op_sw, 5'd0, rt, 6'd0, 8'($urandom), 2'b00};
                11: imem[i] = {op_beq, rs, rt, 16'(tgt - i - 1)};
                12: imem[i] = {op_bne, rs, rt, 16'(tgt - i - 1)};
                13: imem[i] = {op_j, ta[27:2]};
                default: imem[i] = {op_special, rs, rt, rd, 5'd0, fn};
            endcase
            prev_branch = (kind >= 11);
            was_load    = (kind == 9);
            last_rt     = rt;
        end
        imem[loop_idx] = {op_j, loop_pc[27:2]};
    endtask

    task automatic reset_dut();
        running = 1'b0;
        rst     = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check({test_name, " reset data_sram_wen"}, 32'h0, {28'b0, data_sram_wen});
        check({test_name, " reset debug_wb_rf_wen"}, 32'h0, {28'b0, debug_wb_rf_wen});
        check({test_name, " first inst_sram_addr"}, RESET_PC, inst_sram_addr);
        rst     = 1'b0;
        running = 1'b1;
    endtask

    task automatic report(input int errs_before);
        if (errors == errs_before) begin
            $display("test %s passed", test_name);
            n_pass = n_pass + 1;
        end else begin
            $display("test %s failed with %0d errors", test_name, errors - errs_before);
            n_fail = n_fail + 1;
        end
    endtask

    task automatic run_program(input string name, input int mode);
        int errs_before;
        errs_before = errors;
        test_name   = name;
        build_program(mode);
        run_reference();
        reset_dut();
        // end once the trace is drained and the self-loop is in writeback
        @(negedge clk);
        while (!(exp_pc.size() == 0 && debug_wb_pc == loop_pc))
            @(negedge clk);
        if (exp_st_addr.size() != 0) begin
            $display("%s: %0d stores never reached the data SRAM", name, exp_st_addr.size());
            errors = errors + 1;
        end
        for (int i = 0; i < 256; i++)
            check({name, " dmem"}, ref_mem[i], dmem[i]);
        report(errs_before);
    endtask

    // forward-only programs execute at most total_words instructions each
    initial begin
        repeat (n_programs * total_words * 4 + 100) @(posedge clk);
        $display("timeout: the pipeline never reached the end of its program");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        running   = 1'b0;
        errors    = 0;
        n_pass    = 0;
        n_fail    = 0;
        test_name = "reset";
        void'($urandom(32'hed25));
        reset_dut();
        report(0);
        run_program("alu_forwarding", 0);
        run_program("load_use", 1);
        run_program("branch_delay_slot", 2);
        run_program("stores", 3);
        for (int s = 0; s < 5; s++)
            run_program($sformatf("mixed_%0d", s), 4);
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verification
hdl/cpu_pkg.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/regfile.sv
hdl/exe_stage.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/cpu_top.sv
verification/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cpu -f src.f -o tb_cpu \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_cpu | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
